// File: src.f
+incdir+verif
hw/udp_pkg.sv
hw/udp_checksum.sv
hw/udp_header_parser.sv
hw/payload_buffer.sv
hw/udp_parser.sv
verif/udp_parser_tb.sv

// File: verif/udp_frame_gen.svh
`ifndef UDP_FRAME_GEN_SVH
`define UDP_FRAME_GEN_SVH

typedef udp_pkg::byte_t byte_q_t[$];

typedef enum int {
    FAULT_NONE,
    FAULT_ETHTYPE,
    FAULT_VERSION,
    FAULT_IHL,
    FAULT_TTL,
    FAULT_PROTO,
    FAULT_CSUM,
    FAULT_LEN
} fault_t;

// byte offsets inside a frame
localparam int IP_OFF  = 2 * udp_pkg::ETH_ADDR_BYTES + udp_pkg::ETH_TYPE_BYTES;
localparam int UDP_OFF = IP_OFF + udp_pkg::IP_HEADER_BYTES;
localparam int PAY_OFF = UDP_OFF + udp_pkg::UDP_HEADER_BYTES;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_rand();
    gen_state = xorshift32(gen_state);
    return gen_state;
endfunction

function automatic udp_pkg::byte_t rand_byte();
    return udp_pkg::byte_t'(next_rand());
endfunction

// pseudo header, udp header and n payload bytes, folded and inverted
function automatic udp_pkg::word_t csum_of_frame(input byte_q_t f, input int n);
    udp_pkg::sum_t  sum;
    udp_pkg::word_t udp_len;
    int             i;
    udp_len = {f[UDP_OFF + 4], f[UDP_OFF + 5]};
    sum = {24'h0, udp_pkg::IP_PROTO_UDP} + {16'h0, udp_len} + {16'h0, udp_len};
    // ip addresses and both ports
    for (i = IP_OFF + 12; i < UDP_OFF + 4; i += 2)
        sum = sum + {16'h0, f[i], f[i + 1]};
    for (i = 0; i < n; i += 2)
        sum = sum + {16'h0, f[PAY_OFF + i], (i + 1 < n) ? f[PAY_OFF + i + 1] : 8'h00};
    while (sum[31:16] != 16'h0)
        sum = {16'h0, sum[31:16]} + {16'h0, sum[15:0]};
    return ~sum[15:0];
endfunction

function automatic byte_q_t build_frame(input int pay_len, input int pad_len,
                                        input fault_t fault);
    byte_q_t        f;
    udp_pkg::word_t udp_len;
    udp_pkg::word_t ip_len;
    udp_pkg::word_t csum;
    int             i;
    udp_len = udp_pkg::word_t'(pay_len + udp_pkg::UDP_HEADER_BYTES);
    if (fault == FAULT_LEN) begin
        udp_len = udp_len + udp_pkg::word_t'(udp_pkg::BUF_DEPTH);
    end
    ip_len = udp_len + udp_pkg::word_t'(udp_pkg::IP_HEADER_BYTES);
    for (i = 0; i < 2 * udp_pkg::ETH_ADDR_BYTES; i++)
        f.push_back(rand_byte());
    f.push_back((fault == FAULT_ETHTYPE) ? 8'h86 : 8'h08);
    f.push_back((fault == FAULT_ETHTYPE) ? 8'hdd : 8'h00);
    case (fault)
        FAULT_VERSION: f.push_back(8'h65);
        FAULT_IHL:     f.push_back(8'h46);
        default:       f.push_back(8'h45);
    endcase
    f.push_back(8'h00);
    f.push_back(ip_len[15:8]);
    f.push_back(ip_len[7:0]);
    // id, then flags with don't fragment
    f.push_back(rand_byte());
    f.push_back(rand_byte());
    f.push_back(8'h40);
    f.push_back(8'h00);
    f.push_back((fault == FAULT_TTL) ? 8'h00 : 8'h40);
    f.push_back((fault == FAULT_PROTO) ? 8'h06 : udp_pkg::IP_PROTO_UDP);
    // ip checksum, addresses and ports
    for (i = 0; i < 2 + 2 * udp_pkg::IP_ADDR_BYTES + 4; i++)
        f.push_back(rand_byte());
    f.push_back(udp_len[15:8]);
    f.push_back(udp_len[7:0]);
    f.push_back(8'h00);
    f.push_back(8'h00);
    for (i = 0; i < pay_len; i++)
        f.push_back(rand_byte());
    csum = csum_of_frame(f, pay_len);
    f[UDP_OFF + 6] = csum[15:8];
    f[UDP_OFF + 7] = (fault == FAULT_CSUM) ? ~csum[7:0] : csum[7:0];
    // ethernet padding
    for (i = 0; i < pad_len; i++)
        f.push_back(rand_byte());
    return f;
endfunction

// payload bytes the frame must produce, empty when it is dropped
function automatic byte_q_t expected_payload(input byte_q_t f);
    byte_q_t pay;
    int      udp_len;
    int      n;
    int      i;
    if (f.size() < PAY_OFF)
        return pay;
    if ({f[IP_OFF - 2], f[IP_OFF - 1]} != udp_pkg::ETH_TYPE_IPV4)
        return pay;
    if (f[IP_OFF][7:4] != udp_pkg::IP_VERSION_4 || f[IP_OFF][3:0] != udp_pkg::IP_IHL_NO_OPTIONS)
        return pay;
    if (f[IP_OFF + 8] == 8'h00 || f[IP_OFF + 9] != udp_pkg::IP_PROTO_UDP)
        return pay;
    udp_len = {f[UDP_OFF + 4], f[UDP_OFF + 5]};
    if (udp_len < udp_pkg::UDP_HEADER_BYTES ||
        udp_len - udp_pkg::UDP_HEADER_BYTES > udp_pkg::BUF_DEPTH)
        return pay;
    n = udp_len - udp_pkg::UDP_HEADER_BYTES;
    // a frame that ends early cuts the payload short
    if (n > f.size() - PAY_OFF)
        n = f.size() - PAY_OFF;
    if (csum_of_frame(f, n) != {f[UDP_OFF + 6], f[UDP_OFF + 7]})
        return pay;
    for (i = 0; i < n; i++)
        pay.push_back(f[PAY_OFF + i]);
    return pay;
endfunction

`endif

// File: verif/udp_parser_tb.sv
`timescale 1ns/1ps

module udp_parser_tb;

    localparam logic [31:0] SEED = 32'hbfd7_2ab7;

    logic           clock;
    logic           reset;
    logic           in_sof;
    logic           in_eof;
    logic           in_empty;
    logic           out_full;
    udp_pkg::byte_t din;
    logic           in_rd_en;
    logic           out_wr_en;
    logic           out_sof;
    logic           out_eof;
    udp_pkg::byte_t dout;

    // queue entries are {sof, eof, byte}
    logic [9:0]  in_q[$];
    logic [9:0]  exp_q[$];
    logic [9:0]  exp_entry;
    logic [31:0] gen_state;
    logic [31:0] drv_state;
    logic        pop_pending;
    logic        in_jitter;
    logic        out_jitter;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_errors;
    int          test_bytes;
    int          total_bytes;
    int          wd_cycles;
    string       test_name;

    `include "udp_frame_gen.svh"

    udp_parser i_dut (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    task automatic check_byte(input udp_pkg::byte_t actual, input udp_pkg::byte_t expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_mark(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            errors++;
        end
    endtask

    // show-ahead input FIFO whose head leaves after the edge that read it
    always @(posedge clock) begin
        if (!reset && in_rd_en && in_empty) begin
            $display("at %0d ns the DUT read the input FIFO while it was empty", $time);
            errors++;
        end
        pop_pending <= in_rd_en && !reset;
    end

    always @(negedge clock) begin
        if (pop_pending && in_q.size() != 0) begin
            in_q.delete(0);
        end
        drv_state = xorshift32(drv_state);
        out_full  = out_jitter && (drv_state[4:3] == 2'b00);
        if (reset || in_q.size() == 0 || (in_jitter && drv_state[1:0] == 2'b00)) begin
            in_empty = 1'b1;
        end else begin
            in_empty = 1'b0;
            {in_sof, in_eof, din} = in_q[0];
        end
    end

    // output sink compares every byte the DUT writes
    always @(posedge clock) begin
        if (!reset && out_wr_en) begin
            if (out_full) begin
                $display("at %0d ns the DUT wrote byte %h while out_full was high",
                         $time, dout);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("at %0d ns the DUT wrote byte %h that no frame should produce",
                         $time, dout);
                errors++;
            end else begin
                exp_entry = exp_q.pop_front();
                check_byte(dout, exp_entry[7:0], "dout");
                check_mark(out_sof, exp_entry[9], "out_sof");
                check_mark(out_eof, exp_entry[8], "out_eof");
            end
        end
    end

    initial begin
        wd_cycles = 0;
        while (wd_cycles <= 20 * total_bytes + 200) begin
            @(negedge clock);
            wd_cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("Errors found");
        $finish;
    end

    task automatic send_frame(input byte_q_t f);
        byte_q_t exp;
        int      i;
        exp = expected_payload(f);
        for (i = 0; i < f.size(); i++)
            in_q.push_back({i == 0, i == f.size() - 1, f[i]});
        for (i = 0; i < exp.size(); i++)
            exp_q.push_back({i == 0, i == exp.size() - 1, exp[i]});
        test_bytes  += f.size();
        total_bytes += f.size();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        test_bytes  = 0;
    endtask

    task automatic finish_test();
        int n;
        n = 0;
        while ((in_q.size() != 0 || exp_q.size() != 0) && n < 20 * test_bytes + 100) begin
            @(negedge clock);
            n++;
        end
        if (in_q.size() != 0 || exp_q.size() != 0) begin
            $display("test %s stalled: %0d input bytes unread, %0d output bytes missing",
                     test_name, in_q.size(), exp_q.size());
            errors++;
            in_q.delete();
            exp_q.delete();
        end
        // room for late or extra output
        repeat (10) @(negedge clock);
        tests_run++;
        $display("test %0d %s: %0d bytes in, %0d errors", tests_run, test_name, test_bytes,
                 errors - test_errors);
    endtask

    initial begin
        logic [31:0] r;
        int          k;
        fault_t      ft;
        reset       = 1'b1;
        in_sof      = 1'b0;
        in_eof      = 1'b0;
        in_empty    = 1'b1;
        out_full    = 1'b0;
        din         = '0;
        pop_pending = 1'b0;
        in_jitter   = 1'b0;
        out_jitter  = 1'b0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        test_bytes  = 0;
        total_bytes = 0;
        gen_state   = SEED;
        drv_state   = xorshift32(SEED);
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        start_test("reset and good frames");
        check_mark(in_rd_en, 1'b0, "in_rd_en after reset");
        check_mark(out_wr_en, 1'b0, "out_wr_en after reset");
        check_mark(out_sof, 1'b0, "out_sof after reset");
        check_mark(out_eof, 1'b0, "out_eof after reset");
        send_frame(build_frame(18, 0, FAULT_NONE));
        send_frame(build_frame(37, 0, FAULT_NONE));
        send_frame(build_frame(1, 0, FAULT_NONE));
        send_frame(build_frame(256, 0, FAULT_NONE));
        finish_test();

        start_test("header faults");
        for (k = 1; k <= 5; k++) begin
            send_frame(build_frame(20 + k, 0, fault_t'(k)));
            send_frame(build_frame(11 + k, 0, FAULT_NONE));
        end
        finish_test();

        start_test("checksum and length faults");
        send_frame(build_frame(24, 0, FAULT_CSUM));
        send_frame(build_frame(9, 0, FAULT_NONE));
        send_frame(build_frame(30, 0, FAULT_LEN));
        send_frame(build_frame(15, 0, FAULT_CSUM));
        send_frame(build_frame(40, 0, FAULT_NONE));
        finish_test();

        start_test("ethernet padding");
        send_frame(build_frame(5, 13, FAULT_NONE));
        send_frame(build_frame(10, 0, FAULT_NONE));
        send_frame(build_frame(3, 20, FAULT_NONE));
        send_frame(build_frame(2, 5, FAULT_CSUM));
        send_frame(build_frame(12, 6, FAULT_NONE));
        finish_test();

        start_test("random mixed traffic");
        in_jitter  = 1'b1;
        out_jitter = 1'b1;
        for (k = 0; k < 40; k++) begin
            r  = next_rand();
            ft = (r[2:0] >= 3'd6) ? fault_t'(1 + r[5:3] % 7) : FAULT_NONE;
            send_frame(build_frame(1 + int'(r[13:8]), int'(r[18:16]), ft));
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: hw/udp_parser.sv
`timescale 1ns/1ps

module udp_parser (
    input  logic           clock,
    input  logic           reset,
    input  logic           in_sof,
    input  logic           in_eof,
    input  logic           in_empty,
    input  logic           out_full,
    input  udp_pkg::byte_t din,
    output logic           in_rd_en,
    output logic           out_wr_en,
    output logic           out_sof,
    output logic           out_eof,
    output udp_pkg::byte_t dout
);

    // parser to buffer
    logic           wr_en;
    udp_pkg::byte_t wr_data;
    logic           buf_full;

    // parser to checksum
    logic           frame_begin;
    logic           word_valid;
    udp_pkg::word_t word;
    logic           frame_end;
    udp_pkg::word_t csum_field;

    // checksum to buffer
    logic           verdict_valid;
    logic           verdict_ok;

    udp_header_parser i_parser (
        .clock       (clock),
        .reset       (reset),
        .din         (din),
        .in_sof      (in_sof),
        .in_eof      (in_eof),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .buf_full    (buf_full),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .frame_begin (frame_begin),
        .word_valid  (word_valid),
        .word        (word),
        .frame_end   (frame_end),
        .csum_field  (csum_field)
    );

    udp_checksum i_csum (
        .clock         (clock),
        .reset         (reset),
        .frame_begin   (frame_begin),
        .word_valid    (word_valid),
        .word          (word),
        .frame_end     (frame_end),
        .csum_field    (csum_field),
        .verdict_valid (verdict_valid),
        .verdict_ok    (verdict_ok)
    );

    payload_buffer i_buffer (
        .clock         (clock),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .buf_full      (buf_full),
        .verdict_valid (verdict_valid),
        .verdict_ok    (verdict_ok),
        .out_full      (out_full),
        .out_wr_en     (out_wr_en),
        .dout          (dout),
        .out_sof       (out_sof),
        .out_eof       (out_eof)
    );

endmodule

// File: hw/payload_buffer.sv
`timescale 1ns/1ps

module payload_buffer (
    input  logic           clock,
    input  logic           reset,
    input  logic           wr_en,
    input  udp_pkg::byte_t wr_data,
    output logic           buf_full,
    input  logic           verdict_valid,
    input  logic           verdict_ok,
    input  logic           out_full,
    output logic           out_wr_en,
    output udp_pkg::byte_t dout,
    output logic           out_sof,
    output logic           out_eof
);

    udp_pkg::byte_t                mem [udp_pkg::BUF_DEPTH];
    logic [udp_pkg::BUF_DEPTH-1:0] eof_flag;
    udp_pkg::buf_addr_t            wr_ptr;
    udp_pkg::buf_addr_t            cm_ptr;
    udp_pkg::buf_addr_t            rd_ptr;
    logic [7:0]                    last_idx;
    logic                          frame_open;
    logic                          committed;
    logic                          first;

    // full counts uncommitted bytes too, they still hold a slot
    assign buf_full   = (wr_ptr - rd_ptr) == udp_pkg::buf_addr_t'(udp_pkg::BUF_DEPTH);
    assign last_idx   = wr_ptr[7:0] - 8'd1;
    assign frame_open = (wr_ptr != cm_ptr);
    assign committed  = (rd_ptr != cm_ptr);

    assign out_wr_en = committed && !out_full;
    assign dout      = mem[rd_ptr[7:0]];
    assign out_sof   = out_wr_en && first;
    assign out_eof   = out_wr_en && eof_flag[rd_ptr[7:0]];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[7:0]]      <= wr_data;
            eof_flag[wr_ptr[7:0]] <= 1'b0;
        end
        // mark the last byte of a frame that passed
        if (verdict_valid && verdict_ok && frame_open) begin
            eof_flag[last_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            cm_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 9'd1;
            end
            if (verdict_valid) begin
                if (verdict_ok) begin
                    cm_ptr <= wr_ptr;
                end else begin
                    // rewind, the failed frame never becomes visible
                    wr_ptr <= cm_ptr;
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            first  <= 1'b1;
        end else if (out_wr_en) begin
            rd_ptr <= rd_ptr + 9'd1;
            first  <= eof_flag[rd_ptr[7:0]];
        end
    end

endmodule

// File: hw/udp_header_parser.sv
`timescale 1ns/1ps

module udp_header_parser (
    input  logic          clock,
    input  logic          reset,
    input  udp_pkg::byte_t din,
    input  logic          in_sof,
    input  logic          in_eof,
    input  logic          in_empty,
    output logic          in_rd_en,
    input  logic          buf_full,
    output logic          wr_en,
    output udp_pkg::byte_t wr_data,
    output logic          frame_begin,
    output logic          word_valid,
    output udp_pkg::word_t word,
    output logic          frame_end,
    output udp_pkg::word_t csum_field
);

    udp_pkg::parse_state_t state;
    logic [3:0]            cnt;
    udp_pkg::byte_t        hold;
    udp_pkg::word_t        src_port;
    udp_pkg::word_t        dst_port;
    udp_pkg::word_t        udp_len;
    udp_pkg::word_t        pay_cnt;
    udp_pkg::word_t        pay_len;
    udp_pkg::word_t        len_in;
    logic                  len_ok;
    logic                  len_pending;
    logic                  last_word;

    // current byte paired with the one before it
    assign len_in  = {hold, din};
    // a udp length below 8 wraps and fails this too
    assign len_ok  = (len_in - udp_pkg::word_t'(udp_pkg::UDP_HEADER_BYTES))
                     <= udp_pkg::word_t'(udp_pkg::BUF_DEPTH);
    assign pay_len = udp_len - udp_pkg::word_t'(udp_pkg::UDP_HEADER_BYTES);
    assign wr_data = din;

    always_comb begin
        in_rd_en = 1'b0;
        wr_en    = 1'b0;
        case (state)
            udp_pkg::payload: begin
                // the repeated length word takes one cycle without a read
                if (!len_pending && !in_empty && !buf_full) begin
                    in_rd_en = 1'b1;
                    wr_en    = 1'b1;
                end
            end
            default: begin
                in_rd_en = !in_empty;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= udp_pkg::idle;
            cnt         <= '0;
            hold        <= '0;
            src_port    <= '0;
            dst_port    <= '0;
            udp_len     <= '0;
            pay_cnt     <= '0;
            len_pending <= 1'b0;
            last_word   <= 1'b0;
            frame_begin <= 1'b0;
            word_valid  <= 1'b0;
            word        <= '0;
            frame_end   <= 1'b0;
            csum_field  <= '0;
        end else begin
            frame_begin <= 1'b0;
            word_valid  <= 1'b0;
            last_word   <= 1'b0;
            // frame_end follows the last word by one cycle
            frame_end   <= last_word;
            if (in_rd_en) begin
                cnt  <= cnt + 4'd1;
                hold <= din;
            end
            case (state)
                udp_pkg::idle: begin
                    cnt <= '0;
                    if (in_rd_en && in_sof) begin
                        state <= udp_pkg::eth_skip;
                        cnt   <= 4'd1;
                    end
                end
                udp_pkg::eth_skip: begin
                    if (in_rd_en && cnt == 4'(2 * udp_pkg::ETH_ADDR_BYTES - 1)) begin
                        state <= udp_pkg::eth_type;
                        cnt   <= '0;
                    end
                end
                udp_pkg::eth_type: begin
                    if (in_rd_en && cnt == 4'(udp_pkg::ETH_TYPE_BYTES - 1)) begin
                        state <= (len_in == udp_pkg::ETH_TYPE_IPV4) ?
                                 udp_pkg::ip_ver : udp_pkg::drain;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_ver: begin
                    if (in_rd_en) begin
                        state <= (din[7:4] == udp_pkg::IP_VERSION_4 &&
                                  din[3:0] == udp_pkg::IP_IHL_NO_OPTIONS) ?
                                 udp_pkg::ip_skip : udp_pkg::drain;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_skip: begin
                    // tos, total length, id and flags
                    if (in_rd_en &&
                        cnt == 4'(udp_pkg::IP_HEADER_BYTES - 2 * udp_pkg::IP_ADDR_BYTES - 6)) begin
                        state <= udp_pkg::ip_ttl;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_ttl: begin
                    if (in_rd_en) begin
                        state <= (din != 8'h00) ? udp_pkg::ip_proto : udp_pkg::drain;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_proto: begin
                    if (in_rd_en) begin
                        state <= (din == udp_pkg::IP_PROTO_UDP) ?
                                 udp_pkg::ip_csum_skip : udp_pkg::drain;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_csum_skip: begin
                    if (in_rd_en && cnt == 4'd1) begin
                        state <= udp_pkg::ip_src;
                        cnt   <= '0;
                    end
                end
                udp_pkg::ip_src: begin
                    if (in_rd_en && cnt[0]) begin
                        word_valid  <= 1'b1;
                        word        <= len_in;
                        frame_begin <= (cnt == 4'd1);
                        if (cnt == 4'(udp_pkg::IP_ADDR_BYTES - 1)) begin
                            state <= udp_pkg::ip_dst;
                            cnt   <= '0;
                        end
                    end
                end
                udp_pkg::ip_dst: begin
                    if (in_rd_en && cnt[0]) begin
                        word_valid <= 1'b1;
                        word       <= len_in;
                        if (cnt == 4'(udp_pkg::IP_ADDR_BYTES - 1)) begin
                            state <= udp_pkg::udp_src;
                            cnt   <= '0;
                        end
                    end
                end
                udp_pkg::udp_src: begin
                    if (in_rd_en && cnt == 4'd1) begin
                        src_port   <= len_in;
                        // protocol word of the pseudo header
                        word_valid <= 1'b1;
                        word       <= {8'h00, udp_pkg::IP_PROTO_UDP};
                        state      <= udp_pkg::udp_dst;
                        cnt        <= '0;
                    end
                end
                udp_pkg::udp_dst: begin
                    if (in_rd_en && cnt == 4'd1) begin
                        dst_port <= len_in;
                        state    <= udp_pkg::udp_len;
                        cnt      <= '0;
                    end
                end
                udp_pkg::udp_len: begin
                    if (in_rd_en && cnt == 4'd1) begin
                        udp_len    <= len_in;
                        word_valid <= 1'b1;
                        word       <= len_in;
                        state      <= len_ok ? udp_pkg::udp_csum : udp_pkg::drain;
                        cnt        <= '0;
                    end
                end
                udp_pkg::udp_csum: begin
                    if (in_rd_en) begin
                        word_valid <= 1'b1;
                        word       <= cnt[0] ? dst_port : src_port;
                        if (cnt == 4'd1) begin
                            csum_field  <= len_in;
                            len_pending <= 1'b1;
                            pay_cnt     <= '0;
                            state       <= udp_pkg::payload;
                            cnt         <= '0;
                        end
                    end
                end
                udp_pkg::payload: begin
                    if (len_pending) begin
                        len_pending <= 1'b0;
                        word_valid  <= 1'b1;
                        word        <= udp_len;
                        if (pay_len == '0) begin
                            last_word <= 1'b1;
                            state     <= udp_pkg::drain;
                        end
                    end else if (in_rd_en) begin
                        pay_cnt <= pay_cnt + 16'd1;
                        if (pay_cnt[0]) begin
                            word_valid <= 1'b1;
                            word       <= len_in;
                        end
                        if (pay_cnt + 16'd1 == pay_len || in_eof) begin
                            last_word <= 1'b1;
                            state     <= udp_pkg::drain;
                            // odd last byte gets a zero low byte
                            if (!pay_cnt[0]) begin
                                word_valid <= 1'b1;
                                word       <= {din, 8'h00};
                            end
                        end
                    end
                end
                udp_pkg::drain: begin
                    // bytes are thrown away until in_eof
                end
                default: begin
                    state <= udp_pkg::idle;
                end
            endcase
            // in_eof always closes the frame, truncated headers are dropped
            if (in_rd_en && in_eof) begin
                state <= udp_pkg::idle;
                cnt   <= '0;
            end
        end
    end

endmodule

// File: hw/udp_checksum.sv
`timescale 1ns/1ps

module udp_checksum (
    input  logic           clock,
    input  logic           reset,
    input  logic           frame_begin,
    input  logic           word_valid,
    input  udp_pkg::word_t word,
    input  logic           frame_end,
    input  udp_pkg::word_t csum_field,
    output logic           verdict_valid,
    output logic           verdict_ok
);

    udp_pkg::csum_state_t state;
    udp_pkg::sum_t        sum;
    udp_pkg::sum_t        fold_once;
    udp_pkg::sum_t        fold_twice;
    udp_pkg::word_t       csum_rx;
    logic [1:0]           fold_cnt;

    // two folds always clear the upper half of a 32-bit sum
    assign fold_once  = {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};
    assign fold_twice = {16'h0000, fold_once[31:16]} + {16'h0000, fold_once[15:0]};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= udp_pkg::accumulate;
            sum      <= '0;
            csum_rx  <= '0;
            fold_cnt <= '0;
        end else begin
            case (state)
                udp_pkg::accumulate: begin
                    if (frame_begin) begin
                        sum <= {16'h0000, word};
                    end else if (word_valid) begin
                        sum <= sum + {16'h0000, word};
                    end
                    if (frame_end) begin
                        csum_rx  <= csum_field;
                        fold_cnt <= '0;
                        state    <= udp_pkg::fold;
                    end
                end
                udp_pkg::fold: begin
                    sum      <= fold_twice;
                    fold_cnt <= fold_cnt + 2'd1;
                    // the judge cycle takes the last slot of the latency
                    if (fold_cnt == 2'(udp_pkg::CSUM_LATENCY - 2)) begin
                        state <= udp_pkg::judge;
                    end
                end
                udp_pkg::judge: begin
                    state <= udp_pkg::accumulate;
                end
                default: begin
                    state <= udp_pkg::accumulate;
                end
            endcase
        end
    end

    assign verdict_valid = (state == udp_pkg::judge);
    assign verdict_ok    = (state == udp_pkg::judge) && (~sum[15:0] == csum_rx);

endmodule

// File: hw/udp_pkg.sv
package udp_pkg;

    // stream and checksum data types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] sum_t;

    // field and header sizes in bytes
    localparam int ETH_ADDR_BYTES   = 6;
    localparam int ETH_TYPE_BYTES   = 2;
    localparam int IP_HEADER_BYTES  = 20;
    localparam int IP_ADDR_BYTES    = 4;
    localparam int UDP_HEADER_BYTES = 8;

    // protocol constants
    localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;
    localparam logic [3:0]  IP_VERSION_4      = 4'd4;
    localparam logic [3:0]  IP_IHL_NO_OPTIONS = 4'd5;
    localparam logic [7:0]  IP_PROTO_UDP      = 8'h11;

    // payload buffer, pointers carry one extra bit for wrap
    localparam int BUF_DEPTH = 256;
    typedef logic [8:0] buf_addr_t;

    // cycles from frame_end to the verdict
    localparam int CSUM_LATENCY = 2;

    typedef enum logic [4:0] {
        idle,
        eth_skip,
        eth_type,
        ip_ver,
        ip_skip,
        ip_ttl,
        ip_proto,
        ip_csum_skip,
        ip_src,
        ip_dst,
        udp_src,
        udp_dst,
        udp_len,
        udp_csum,
        payload,
        drain
    } parse_state_t;

    typedef enum logic [1:0] {
        accumulate,
        fold,
        judge
    } csum_state_t;

endpackage
